/* flist.f */
src/pixel_stream_pkg.sv
src/ui_layout_pkg.sv
src/button_event_tracker.sv
src/glyph_raster.sv
src/volume_bar_raster.sv
src/pixel_compositor.sv
src/mp3_overlay_top.sv
testbench/tb_mp3_overlay.sv

/* src/button_event_tracker.sv */
module button_event_tracker #(
    parameter int HOLD_SHORT = 50,
    parameter int HOLD_LONG  = 5000
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   i_next,
    input  logic                   i_prev,
    input  logic                   i_pause,
    output ui_layout_pkg::hilite_t o_hilite
);
    import ui_layout_pkg::*;

    // counter sized for the longer hold
    localparam int CNT_W = $clog2(HOLD_LONG + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SHORT,
        ST_LONG
    } state_t;

    state_t           state_q;
    logic [CNT_W-1:0] hold_cnt_q;
    logic             pause_q;
    logic             pause_chg;
    logic             hold_done;
    hilite_t          hilite_q;

    assign pause_chg = (i_pause != pause_q);

    always_comb begin
        case (state_q)
            ST_SHORT: hold_done = (hold_cnt_q == CNT_W'(HOLD_SHORT));
            ST_LONG:  hold_done = (hold_cnt_q == CNT_W'(HOLD_LONG));
            default:  hold_done = 1'b0;
        endcase
    end

    // pause level is tracked every cycle so changes during a hold are dropped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= ST_IDLE;
            hold_cnt_q <= '0;
            pause_q    <= 1'b0;
            hilite_q   <= '0;
        end else begin
            pause_q <= i_pause;
            case (state_q)
                ST_IDLE: begin
                    hold_cnt_q <= '0;
                    // next beats prev, both beat a pause change
                    if (i_next) begin
                        hilite_q.next <= 1'b1;
                        state_q       <= ST_SHORT;
                    end else if (i_prev) begin
                        hilite_q.prev <= 1'b1;
                        state_q       <= ST_SHORT;
                    end else if (pause_chg) begin
                        hilite_q.play <= 1'b1;
                        state_q       <= ST_LONG;
                    end
                end
                default: begin
                    if (hold_done) begin
                        hilite_q <= '0;
                        state_q  <= ST_IDLE;
                    end else begin
                        hold_cnt_q <= hold_cnt_q + 1'b1;
                    end
                end
            endcase
        end
    end

    assign o_hilite = hilite_q;

    // only one box may be lit at any time
    a_hilite_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(hilite_q));

endmodule

/* src/glyph_raster.sv */
module glyph_raster #(
    parameter int H_RES = 640,
    parameter int V_RES = 480
) (
    input  pixel_stream_pkg::pix_req_t i_pix,
    input  logic                       i_pause,
    input  ui_layout_pkg::hilite_t     i_hilite,
    output logic                       o_glyph,
    output logic                       o_hilite_hit
);

    ////////////////////////////////////////////////////////////////////////////
    // geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int SQ      = V_RES / 64;
    localparam int SX      = H_RES / 2;
    localparam int SY      = 3 * V_RES / 4;
    localparam int SX_NEXT = SX + 16 * SQ;
    localparam int SX_PREV = SX - 16 * SQ;
    localparam int SY_MID  = SY + 2 * SQ;
    localparam int SY_END  = SY + 4 * SQ;
    // highlight box margin around each glyph
    localparam int BOX     = 3;

    int   px;
    int   py;
    logic play_tri;
    logic pause_bars;
    logic next_tri;
    logic next_bar;
    logic prev_tri;
    logic prev_bar;
    logic play_box;
    logic next_box;
    logic prev_box;

    function automatic logic in_rect(int x, int y, int x0, int y0, int x1, int y1);
        return (x >= x0) && (x < x1) && (y >= y0) && (y < y1);
    endfunction

    // triangle half-width, widest at the middle row
    function automatic int tri_width(int y);
        return (y > SY_MID) ? (SY_END - y) : (y - SY);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // hit tests
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        px = i_pix.x;
        py = i_pix.y;

        // right pointing, flat side at x0
        play_tri = (py >= SY) && (py < SY_END) && (px >= SX) && (px < SX + tri_width(py));
        next_tri = (py >= SY) && (py < SY_END) && (px >= SX_NEXT)
                   && (px < SX_NEXT + tri_width(py));
        // mirror of next, flat side at SX_PREV + 2*SQ
        prev_tri = (py >= SY) && (py < SY_END) && (px < SX_PREV + 2 * SQ)
                   && (px >= SX_PREV + 2 * SQ - tri_width(py));

        pause_bars = in_rect(px, py, SX, SY, SX + SQ, SY_END)
                     || in_rect(px, py, SX + 2 * SQ, SY, SX + 3 * SQ, SY_END);
        next_bar   = in_rect(px, py, SX_NEXT - 2 * SQ, SY, SX_NEXT - SQ, SY_END);
        prev_bar   = in_rect(px, py, SX_PREV + 3 * SQ, SY, SX_PREV + 4 * SQ, SY_END);

        play_box = in_rect(px, py, SX - BOX, SY - BOX, SX + 3 * SQ + BOX, SY_END + BOX);
        next_box = in_rect(px, py, SX_NEXT - 2 * SQ - BOX, SY - BOX,
                           SX_NEXT + 2 * SQ + BOX, SY_END + BOX);
        prev_box = in_rect(px, py, SX_PREV - BOX, SY - BOX,
                           SX_PREV + 4 * SQ + BOX, SY_END + BOX);
    end

    // play shape while paused, pause bars while playing
    assign o_glyph = (i_pause && play_tri) || (!i_pause && pause_bars)
                     || next_tri || next_bar || prev_tri || prev_bar;

    assign o_hilite_hit = (i_hilite.play && play_box) || (i_hilite.next && next_box)
                          || (i_hilite.prev && prev_box);

endmodule

/* src/mp3_overlay_top.sv */
module mp3_overlay_top #(
    parameter int H_RES      = 640,
    parameter int V_RES      = 480,
    parameter int HOLD_SHORT = 50,
    parameter int HOLD_LONG  = 5000,
    parameter int CREDITS    = 4
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       i_pix_valid,
    input  pixel_stream_pkg::pix_req_t i_pix,
    input  logic                       i_credit_ret,
    input  logic                       i_next,
    input  logic                       i_prev,
    input  logic                       i_pause,
    input  logic                       i_vol_active,
    input  logic [3:0]                 i_vol_atten,
    output logic                       o_pix_ready,
    output logic                       o_pix_valid,
    output pixel_stream_pkg::rgb_t     o_pix
);
    import ui_layout_pkg::*;

    hilite_t hilite;
    hit_t    hit;
    logic    vol_hit;

    button_event_tracker #(
        .HOLD_SHORT (HOLD_SHORT),
        .HOLD_LONG  (HOLD_LONG)
    ) u_tracker (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_next   (i_next),
        .i_prev   (i_prev),
        .i_pause  (i_pause),
        .o_hilite (hilite)
    );

    glyph_raster #(
        .H_RES (H_RES),
        .V_RES (V_RES)
    ) u_glyph (
        .i_pix        (i_pix),
        .i_pause      (i_pause),
        .i_hilite     (hilite),
        .o_glyph      (hit.glyph),
        .o_hilite_hit (hit.hilite)
    );

    volume_bar_raster #(
        .H_RES (H_RES),
        .V_RES (V_RES)
    ) u_volume (
        .i_pix       (i_pix),
        .i_vol_atten (i_vol_atten),
        .o_vol       (vol_hit)
    );

    // on-screen frame strip of BORDER_W pixels
    assign hit.border = (i_pix.x >= 0) && (i_pix.x < H_RES)
                        && (i_pix.y >= 0) && (i_pix.y < V_RES)
                        && ((i_pix.x < BORDER_W) || (i_pix.x >= H_RES - BORDER_W)
                            || (i_pix.y < BORDER_W) || (i_pix.y >= V_RES - BORDER_W));

    // column only shows while a volume key is held
    assign hit.vol = vol_hit && i_vol_active;

    pixel_compositor #(
        .CREDITS (CREDITS)
    ) u_compositor (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_pix_valid  (i_pix_valid),
        .i_credit_ret (i_credit_ret),
        .i_hit        (hit),
        .i_pause      (i_pause),
        .o_pix_ready  (o_pix_ready),
        .o_pix_valid  (o_pix_valid),
        .o_pix        (o_pix)
    );

endmodule

/* src/pixel_compositor.sv */
module pixel_compositor #(
    parameter int CREDITS = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   i_pix_valid,
    input  logic                   i_credit_ret,
    input  ui_layout_pkg::hit_t    i_hit,
    input  logic                   i_pause,
    output logic                   o_pix_ready,
    output logic                   o_pix_valid,
    output pixel_stream_pkg::rgb_t o_pix
);
    import pixel_stream_pkg::*;
    import ui_layout_pkg::*;

    localparam int CW = $clog2(CREDITS + 1);

    logic [CW-1:0] credit_q;
    logic          accept;
    logic          s1_valid_q;
    logic          s2_valid_q;
    hit_t          s1_hit_q;
    logic          s1_pause_q;
    rgb_t          color_d;
    rgb_t          color_q;

    ////////////////////////////////////////////////////////////////////////////
    // credit counter
    ////////////////////////////////////////////////////////////////////////////

    assign o_pix_ready = (credit_q != '0);
    assign accept      = i_pix_valid && o_pix_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_q <= CW'(CREDITS);
        end else begin
            case ({accept, i_credit_ret})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: credit_q <= credit_q;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // two-stage pipeline that never stalls
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= accept;
            s2_valid_q <= s1_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_hit_q   <= i_hit;
            s1_pause_q <= i_pause;
        end
        if (s1_valid_q) begin
            color_q <= color_d;
        end
    end

    // colour priority with the glyph on top
    always_comb begin
        if (s1_hit_q.glyph) begin
            color_d = COLOR_ICON;
        end else if (s1_hit_q.hilite) begin
            color_d = COLOR_HILITE;
        end else if (s1_hit_q.border && !s1_pause_q) begin
            color_d = COLOR_BORDER;
        end else if (s1_hit_q.vol) begin
            color_d = COLOR_VOL;
        end else begin
            color_d = COLOR_BG;
        end
    end

    assign o_pix_valid = s2_valid_q;
    assign o_pix       = color_q;

    // sink must never return more credits than it was given
    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credit_q <= CW'(CREDITS));

    // every pixel in the pipe still holds the credit it took on entry
    a_no_overdraw: assert property (@(posedge clk) disable iff (!rst_n)
        int'(s1_valid_q) + int'(s2_valid_q) + int'(credit_q) <= CREDITS);

endmodule

/* src/pixel_stream_pkg.sv */
package pixel_stream_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // stream word formats
    ////////////////////////////////////////////////////////////////////////////

    localparam int COORD_W = 16;
    localparam int CHAN_W  = 4;

    // screen coordinate, signed so off-screen requests compare sanely
    typedef logic signed [COORD_W-1:0] coord_t;

    // 12-bit colour, 4 bits per channel
    typedef struct packed {
        logic [CHAN_W-1:0] red;
        logic [CHAN_W-1:0] green;
        logic [CHAN_W-1:0] blue;
    } rgb_t;

    // one pixel request from the upstream source
    typedef struct packed {
        coord_t x;
        coord_t y;
    } pix_req_t;

    // channel saturation value
    localparam logic [CHAN_W-1:0] CHAN_FULL = '1;
    localparam logic [CHAN_W-1:0] CHAN_ZERO = '0;

endpackage

/* src/ui_layout_pkg.sv */
package ui_layout_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // palette
    ////////////////////////////////////////////////////////////////////////////

    localparam pixel_stream_pkg::rgb_t COLOR_ICON = '{
        red:   pixel_stream_pkg::CHAN_FULL,
        green: pixel_stream_pkg::CHAN_FULL,
        blue:  pixel_stream_pkg::CHAN_FULL
    };

    // yellow box around an active glyph
    localparam pixel_stream_pkg::rgb_t COLOR_HILITE = '{
        red:   pixel_stream_pkg::CHAN_FULL,
        green: pixel_stream_pkg::CHAN_FULL,
        blue:  pixel_stream_pkg::CHAN_ZERO
    };

    localparam pixel_stream_pkg::rgb_t COLOR_VOL = COLOR_ICON;

    // fixed border tint while playing
    localparam pixel_stream_pkg::rgb_t COLOR_BORDER = '{
        red:   pixel_stream_pkg::CHAN_ZERO,
        green: pixel_stream_pkg::CHAN_FULL,
        blue:  pixel_stream_pkg::CHAN_FULL
    };

    localparam pixel_stream_pkg::rgb_t COLOR_BG = '0;

    ////////////////////////////////////////////////////////////////////////////
    // layout constants and hit flags
    ////////////////////////////////////////////////////////////////////////////

    localparam int BORDER_W     = 15;
    localparam int VOL_SEGMENTS = 8;

    // per-pixel hit flags, filled by the raster side
    typedef struct packed {
        logic glyph;
        logic hilite;
        logic border;
        logic vol;
    } hit_t;

    // highlight flags, at most one set at a time
    typedef struct packed {
        logic next;
        logic prev;
        logic play;
    } hilite_t;

endpackage

/* src/volume_bar_raster.sv */
module volume_bar_raster #(
    parameter int H_RES = 640,
    parameter int V_RES = 480
) (
    input  pixel_stream_pkg::pix_req_t i_pix,
    input  logic [3:0]                 i_vol_atten,
    output logic                       o_vol
);
    import ui_layout_pkg::*;

    localparam int SQ = V_RES / 64;
    // column left edge and bottom line
    localparam int VX = H_RES / 2 + 36 * SQ;
    localparam int VB = 3 * V_RES / 4 - SQ;

    int                      px;
    int                      py;
    int                      lit_cnt;
    logic                    in_col;
    logic [VOL_SEGMENTS-1:0] lit_mask;
    logic [VOL_SEGMENTS-1:0] seg_hit;

    always_comb begin
        px = i_pix.x;
        py = i_pix.y;

        // lit segments, floored at zero
        if (int'(i_vol_atten) >= VOL_SEGMENTS) begin
            lit_cnt = 0;
        end else begin
            lit_cnt = VOL_SEGMENTS - int'(i_vol_atten);
        end

        in_col = (px >= VX) && (px < VX + 2 * SQ);

        // segment 0 at the bottom, each one SQ tall on a 2*SQ pitch
        for (int k = 0; k < VOL_SEGMENTS; k++) begin
            lit_mask[k] = (k < lit_cnt);
            seg_hit[k]  = in_col && (py >= VB - (2 * k + 1) * SQ) && (py < VB - 2 * k * SQ);
        end
    end

    assign o_vol = |(seg_hit & lit_mask);

endmodule

/* testbench/tb_mp3_overlay.sv */
module tb_mp3_overlay;
    import pixel_stream_pkg::*;
    import ui_layout_pkg::*;

    localparam int H_RES      = 640;
    localparam int V_RES      = 480;
    localparam int HOLD_SHORT = 20;
    localparam int HOLD_LONG  = 60;
    localparam int CREDITS    = 4;

    // screen layout, rebuilt from the geometry rules
    localparam int SQ = V_RES / 64;
    localparam int SX = H_RES / 2;
    localparam int SY = 3 * V_RES / 4;
    localparam int NX = SX + 16 * SQ;
    localparam int PX = SX - 16 * SQ;
    localparam int VX = SX + 36 * SQ;
    localparam int VB = SY - SQ;

    localparam int HL_NONE = 0;
    localparam int HL_NEXT = 1;
    localparam int HL_PREV = 2;
    localparam int HL_PLAY = 3;

    // pixel counts per test, the watchdog budget follows from them
    localparam int N_RAND    = 40;
    localparam int N_CREDIT  = 30;
    localparam int N_ATTEN   = 12;
    localparam int N_EDGE    = 20;
    localparam int TOTAL_PIX = CREDITS + N_CREDIT + 2 * (6 + N_RAND)
                               + (HOLD_SHORT + 10) + 25 + (HOLD_LONG + 10)
                               + (N_ATTEN + 1) * VOL_SEGMENTS + 2 * (4 + N_EDGE);
    localparam int MAX_CYCLES = 8 * TOTAL_PIX + 300;

    logic       clk;
    logic       rst_n;
    logic       i_pix_valid;
    pix_req_t   i_pix;
    logic       i_credit_ret;
    logic       i_next;
    logic       i_prev;
    logic       i_pause;
    logic       i_vol_active;
    logic [3:0] i_vol_atten;
    logic       o_pix_ready;
    logic       o_pix_valid;
    rgb_t       o_pix;

    // reference state
    rgb_t exp_q[$];
    rgb_t exp_head  = COLOR_BG;
    logic exp_empty = 1'b1;
    int   credits   = CREDITS;
    int   owed      = 0;
    int   sink_mode = 0;
    int   hl_kind   = HL_NONE;
    int   hl_left   = 0;
    logic pause_prev = 1'b0;

    mp3_overlay_top #(
        .H_RES      (H_RES),
        .V_RES      (V_RES),
        .HOLD_SHORT (HOLD_SHORT),
        .HOLD_LONG  (HOLD_LONG),
        .CREDITS    (CREDITS)
    ) dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_pix_valid  (i_pix_valid),
        .i_pix        (i_pix),
        .i_credit_ret (i_credit_ret),
        .i_next       (i_next),
        .i_prev       (i_prev),
        .i_pause      (i_pause),
        .i_vol_active (i_vol_active),
        .i_vol_atten  (i_vol_atten),
        .o_pix_ready  (o_pix_ready),
        .o_pix_valid  (o_pix_valid),
        .o_pix        (o_pix)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(MAX_CYCLES * 4);
        stop_with_failure("timeout, the stimulus did not finish in time");
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference colour model
    ////////////////////////////////////////////////////////////////////////////

    function automatic bit in_box(int x, int y, int x0, int y0, int w, int h);
        return (x >= x0) && (x < x0 + w) && (y >= y0) && (y < y0 + h);
    endfunction

    // triangle half width, zero outside the glyph rows
    function automatic int tri_half(int y);
        int r;
        r = y - SY;
        if (r < 0 || r >= 4 * SQ) begin
            return 0;
        end
        return (r <= 2 * SQ) ? r : 4 * SQ - r;
    endfunction

    function automatic rgb_t ref_color(int x, int y, logic pause, logic vol_on,
                                       int atten, int hl);
        int w;
        int lit;
        bit glyph;
        bit box;
        bit frame;
        bit vol;
        w     = tri_half(y);
        glyph = in_box(x, y, NX - 2 * SQ, SY, SQ, 4 * SQ)
                || in_box(x, y, PX + 3 * SQ, SY, SQ, 4 * SQ)
                || (x - NX >= 0 && x - NX < w)
                || (PX + 2 * SQ - 1 - x >= 0 && PX + 2 * SQ - 1 - x < w);
        if (pause) begin
            glyph = glyph || (x - SX >= 0 && x - SX < w);
        end else begin
            glyph = glyph || in_box(x, y, SX, SY, SQ, 4 * SQ)
                    || in_box(x, y, SX + 2 * SQ, SY, SQ, 4 * SQ);
        end
        case (hl)
            HL_NEXT: box = in_box(x, y, NX - 2 * SQ - 3, SY - 3, 4 * SQ + 6, 4 * SQ + 6);
            HL_PREV: box = in_box(x, y, PX - 3, SY - 3, 4 * SQ + 6, 4 * SQ + 6);
            HL_PLAY: box = in_box(x, y, SX - 3, SY - 3, 3 * SQ + 6, 4 * SQ + 6);
            default: box = 1'b0;
        endcase
        frame = in_box(x, y, 0, 0, H_RES, V_RES) && !in_box(x, y, BORDER_W, BORDER_W,
                H_RES - 2 * BORDER_W, V_RES - 2 * BORDER_W);
        lit = (atten >= VOL_SEGMENTS) ? 0 : VOL_SEGMENTS - atten;
        vol = 1'b0;
        for (int k = 0; k < lit; k++) begin
            vol = vol || in_box(x, y, VX, VB - (2 * k + 1) * SQ, 2 * SQ, SQ);
        end
        if (glyph) return COLOR_ICON;
        if (box) return COLOR_HILITE;
        if (frame && !pause) return COLOR_BORDER;
        if (vol && vol_on) return COLOR_VOL;
        return COLOR_BG;
    endfunction

    // credits, expected pixels and highlight timing, all at the clock edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (o_pix_valid) begin
                if (exp_q.size() > 0) begin
                    void'(exp_q.pop_front());
                end
                owed++;
            end
            if (i_pix_valid && credits > 0) begin
                exp_q.push_back(ref_color(i_pix.x, i_pix.y, i_pause, i_vol_active,
                                          i_vol_atten, hl_kind));
                credits--;
            end
            if (i_credit_ret) begin
                owed--;
                credits++;
            end
            if (hl_left > 0) begin
                hl_left--;
                if (hl_left == 0) begin
                    hl_kind = HL_NONE;
                end
            end else if (i_next) begin
                hl_kind = HL_NEXT;
                hl_left = HOLD_SHORT + 1;
            end else if (i_prev) begin
                hl_kind = HL_PREV;
                hl_left = HOLD_SHORT + 1;
            end else if (i_pause != pause_prev) begin
                hl_kind = HL_PLAY;
                hl_left = HOLD_LONG + 1;
            end
            pause_prev = i_pause;
            exp_empty  = (exp_q.size() == 0);
            exp_head   = exp_empty ? COLOR_BG : exp_q[0];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // output checks
    ////////////////////////////////////////////////////////////////////////////

    a_pix_color: assert property (@(posedge clk) disable iff (!rst_n)
        (o_pix_valid && !exp_empty) |-> (o_pix == exp_head))
        else stop_with_failure($sformatf("Error o_pix expected %h got %h",
                                         $sampled(exp_head), $sampled(o_pix)));

    a_no_extra: assert property (@(posedge clk) disable iff (!rst_n)
        o_pix_valid |-> !exp_empty)
        else stop_with_failure("output pixel appeared with no pixel in flight");

    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (i_pix_valid && o_pix_ready) |-> ##2 o_pix_valid)
        else stop_with_failure("accepted pixel did not come out two cycles later");

    a_ready: assert property (@(posedge clk) disable iff (!rst_n)
        o_pix_ready == (credits > 0))
        else stop_with_failure($sformatf("Error o_pix_ready expected %h got %h",
                                         $sampled(credits > 0), $sampled(o_pix_ready)));

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // downstream sink, returns only credits it has been paid
    task automatic run_sink();
        forever begin
            step();
            i_credit_ret = (owed > 0)
                           && (sink_mode == 1 || (sink_mode == 2 && $urandom_range(1, 0) == 1));
        end
    endtask

    task automatic send_pix(input int x, input int y);
        logic took;
        i_pix.x     = coord_t'(x);
        i_pix.y     = coord_t'(y);
        i_pix_valid = 1'b1;
        took        = 1'b0;
        while (!took) begin
            took = o_pix_ready;
            step();
        end
        i_pix_valid = 1'b0;
    endtask

    task automatic send_rand(input int n, input int x0, input int y0, input int w, input int h);
        repeat (n) begin
            send_pix(x0 + $urandom_range(w - 1, 0), y0 + $urandom_range(h - 1, 0));
        end
    endtask

    task automatic send_repeat(input int x, input int y, input int n);
        repeat (n) send_pix(x, y);
    endtask

    task automatic pulse_button(input bit nxt);
        i_next = nxt;
        i_prev = !nxt;
        step();
        i_next = 1'b0;
        i_prev = 1'b0;
    endtask

    task automatic wait_credits_full();
        sink_mode = 1;
        while (credits != CREDITS) step();
    endtask

    initial begin
        rst_n        = 1'b0;
        i_pix_valid  = 1'b0;
        i_pix        = '0;
        i_credit_ret = 1'b0;
        i_next       = 1'b0;
        i_prev       = 1'b0;
        i_pause      = 1'b0;
        i_vol_active = 1'b0;
        i_vol_atten  = '0;
        void'($urandom(32'he72762ef));
        fork
            run_sink();
        join_none
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        step();

        // sink holds every credit, then returns them at random
        sink_mode = 0;
        send_rand(CREDITS, 0, 0, H_RES, V_RES);
        i_pix_valid = 1'b1;
        repeat (10) step();
        sink_mode = 2;
        send_rand(N_CREDIT, 0, 0, H_RES, V_RES);

        // glyph shapes in both player states
        for (int p = 0; p < 2; p++) begin
            i_pause = p[0];
            send_pix(SX + SQ + 2, SY + 2 * SQ);
            send_pix(SX + 2 * SQ + 1, SY + SQ);
            send_pix(NX + 2, SY + 2 * SQ);
            send_pix(NX - 2 * SQ + 1, SY + 1);
            send_pix(PX + 2 * SQ - 3, SY + 2 * SQ);
            send_pix(PX + 3 * SQ + 1, SY + 5);
            send_rand(N_RAND, PX - 10, SY - 10, NX - PX + 2 * SQ + 20, 4 * SQ + 20);
        end
        i_pause = 1'b0;
        wait_credits_full();
        repeat (HOLD_LONG + 2) step();

        // next box, with repeat presses inside the hold window
        fork
            send_repeat(NX - 2 * SQ - 2, SY, HOLD_SHORT + 10);
            begin
                pulse_button(1'b1);
                repeat (8) step();
                pulse_button(1'b1);
                pulse_button(1'b0);
            end
        join
        fork
            send_repeat(PX - 2, SY, 25);
            pulse_button(1'b0);
        join
        fork
            send_repeat(SX - 2, SY + SQ, HOLD_LONG + 10);
            begin
                repeat (3) step();
                i_pause = 1'b1;
            end
        join

        // volume column, segment centres bottom up
        sink_mode    = 2;
        i_vol_active = 1'b1;
        for (int a = 0; a <= N_ATTEN; a++) begin
            if (a == N_ATTEN) begin
                i_vol_active = 1'b0;
            end
            i_vol_atten = 4'($urandom_range(15, 0));
            for (int k = 0; k < VOL_SEGMENTS; k++) begin
                send_pix(VX + SQ, VB - 2 * k * SQ - SQ / 2 - 1);
            end
        end

        // frame strip, on and off screen
        for (int p = 0; p < 2; p++) begin
            i_pause = p[0];
            send_pix(0, 0);
            send_pix(H_RES - 1, V_RES - 1);
            send_pix(-3, 20);
            send_pix(H_RES, 20);
            send_rand(N_EDGE, 0, 0, H_RES, BORDER_W + 5);
        end

        wait_credits_full();
        repeat (4) step();
        if (exp_q.size() != 0 || credits != CREDITS) begin
            stop_with_failure("pixels were still in flight after the drain");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule
